// File: sim/spinn_aer_stim.txt
// Columns: op value expect, all hex
// op 0 good link, 1 bad parity, 2 foreign prefix, 3 nine symbols, 4 AER event, 5 hold AER ack
0 1234 1
4 a5a5 1
0 0001 1
1 beef 0
4 0000 1
0 cafe 1
2 5555 0
3 7777 0
0 8000 1
4 ffff 1
5 0000 0
0 1001 1
0 2002 1
4 3c3c 1
0 3003 1
0 4004 1
0 5005 1
0 6006 1
4 0ff0 1
4 8421 1

// File: tb.f
logic/spinn_aer_pkg.sv
logic/pkt_chan_if.sv
logic/pkt_fifo.sv
logic/spl_rx.sv
logic/spl_tx.sv
logic/aer_rx.sv
logic/aer_tx.sv
logic/spinn_aer_bridge.sv
sim/spinn_aer_tb.sv

// File: Makefile
SIM  := obj_dir/Vspinn_aer_tb
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal --top-module spinn_aer_tb -f tb.f

run: $(SIM) sim/spinn_aer_stim.txt
	./$(SIM)

clean:
	rm -rf obj_dir

// File: sim/spinn_aer_tb.sv
// Testbench for the link to AER bridge with file-driven link and AER peers and scoreboards
`timescale 1ns/1ps
module spinn_aer_tb;

  localparam logic [15:0] KEY_PREFIX  = 16'hffff;
  localparam int          FIFO_DEPTH  = 4;
  localparam int          NUM_LINES   = 20;
  localparam int          HOLD_CYCLES = 400;

  // 2-of-7 nibble codes indexed by nibble
  localparam logic [6:0] SYM_CODE [16] = '{
    7'h11, 7'h12, 7'h14, 7'h18, 7'h21, 7'h22, 7'h24, 7'h28,
    7'h41, 7'h42, 7'h44, 7'h48, 7'h03, 7'h06, 7'h0c, 7'h09};
  localparam logic [6:0] EOP_SYM = 7'h60;

  logic        clk;
  logic        rst_n;
  logic [6:0]  spl_rx_data;
  logic        spl_rx_ack;
  logic [6:0]  spl_tx_data;
  logic        spl_tx_ack;
  logic [15:0] aer_rx_data;
  logic        aer_rx_req_n;
  logic        aer_rx_ack_n;
  logic [15:0] aer_tx_data;
  logic        aer_tx_req_n;
  logic        aer_tx_ack_n;

  // Three words per stimulus line for op, value and expect flag
  logic [15:0] stim_mem [3*NUM_LINES];
  integer      seed;
  // Scoreboards for link to AER and AER to link
  logic [15:0] aer_exp [$];
  logic [15:0] link_exp [$];
  logic        hold_on;
  int          link_total;
  int          link_done;
  // Link sender state
  logic [6:0]  rx_word;
  logic        rx_ack_seen;

  spinn_aer_bridge #(
    .KEY_PREFIX (KEY_PREFIX),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .spl_rx_data  (spl_rx_data),
    .spl_rx_ack   (spl_rx_ack),
    .spl_tx_data  (spl_tx_data),
    .spl_tx_ack   (spl_tx_ack),
    .aer_rx_data  (aer_rx_data),
    .aer_rx_req_n (aer_rx_req_n),
    .aer_rx_ack_n (aer_rx_ack_n),
    .aer_tx_data  (aer_tx_data),
    .aer_tx_req_n (aer_tx_req_n),
    .aer_tx_ack_n (aer_tx_ack_n)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [39:0] got, input logic [39:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
  endtask

  // Random wait of 1 to max_cycles falling edges
  task automatic rand_wait(input int max_cycles);
    int n;
    n = 1 + int'({$random(seed)} % max_cycles);
    repeat (n) @(negedge clk);
  endtask

  // Packet from the header and key rules with the fault the op asks for
  function automatic logic [39:0] link_packet(input logic [15:0] op, input logic [15:0] value);
    logic [31:0] key;
    logic [7:0]  hdr;
    key = (op == 16'd2) ? {KEY_PREFIX ^ 16'h0f0f, value} : {KEY_PREFIX, value};
    hdr = {7'b0000000, ~(^key)};
    if (op == 16'd1)
      hdr[0] = ~hdr[0];
    return {key, hdr};
  endfunction

  // Flip one code on the wires, then wait for the ack toggle
  task automatic send_link_sym(input logic [6:0] code);
    rx_word     = rx_word ^ code;
    spl_rx_data = rx_word;
    @(negedge clk);
    while (spl_rx_ack == rx_ack_seen)
      @(negedge clk);
    rx_ack_seen = spl_rx_ack;
  endtask

  task automatic send_link_pkt(input logic [39:0] pkt, input int nsym);
    for (int i = 0; i < nsym; i++)
      send_link_sym(SYM_CODE[pkt[4*i +: 4]]);
    send_link_sym(EOP_SYM);
  endtask

  // --------------------------------------------------
  // Senders
  // --------------------------------------------------
  task automatic run_link_side();
    logic [15:0] op;
    logic [15:0] value;
    for (int l = 0; l < NUM_LINES; l++)
    begin
      op    = stim_mem[3*l];
      value = stim_mem[3*l+1];
      if (op == 16'd5)
        hold_on = 1'b1;
      else if (op != 16'd4)
      begin
        if (op == 16'd0)
          aer_exp.push_back(value);
        send_link_pkt(link_packet(op, value), (op == 16'd3) ? 9 : 10);
        link_done++;
        repeat (2) @(negedge clk);
      end
    end
  endtask

  task automatic run_aer_side();
    logic [15:0] value;
    for (int l = 0; l < NUM_LINES; l++)
    begin
      value = stim_mem[3*l+1];
      if (stim_mem[3*l] == 16'd4)
      begin
        link_exp.push_back(value);
        aer_rx_data = value;
        @(negedge clk);
        aer_rx_req_n = 1'b0;
        while (aer_rx_ack_n)
          @(negedge clk);
        aer_rx_req_n = 1'b1;
        while (!aer_rx_ack_n)
          @(negedge clk);
        rand_wait(4);
      end
    end
  endtask

  // --------------------------------------------------
  // Receivers
  // --------------------------------------------------

  // AER sink that holds off its ack while hold_on is set
  initial
  begin
    logic [15:0] held;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (!aer_tx_req_n)
      begin
        held = aer_tx_data;
        if (aer_exp.size() == 0)
          abort_run("AER event arrived with no good link packet pending");
        check("aer_tx_data", {24'h0, held}, {24'h0, aer_exp.pop_front()});
        while (hold_on)
        begin
          check("aer_tx_data stable", {24'h0, aer_tx_data}, {24'h0, held});
          @(negedge clk);
        end
        rand_wait(6);
        aer_tx_ack_n = 1'b0;
        while (!aer_tx_req_n)
        begin
          check("aer_tx_data stable", {24'h0, aer_tx_data}, {24'h0, held});
          @(negedge clk);
        end
        rand_wait(6);
        aer_tx_ack_n = 1'b1;
      end
    end
  end

  // Link sink that shifts LS nibble first into a 40-bit packet
  initial
  begin
    logic [6:0]  last;
    logic [6:0]  trans;
    logic [39:0] pkt;
    logic [31:0] key;
    int          nsym;
    int          nib;
    last = '0;
    pkt  = '0;
    nsym = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (spl_tx_data != last)
      begin
        trans = spl_tx_data ^ last;
        last  = spl_tx_data;
        check("spl_tx_data flipped wires", 40'($countones(trans)), 40'd2);
        if (trans == EOP_SYM)
        begin
          check("link symbol count", 40'(nsym), 40'd10);
          check("link packet parity", {39'h0, ^pkt}, 40'h1);
          if (link_exp.size() == 0)
            abort_run("Link packet arrived with no AER event pending");
          key = {KEY_PREFIX, link_exp.pop_front()};
          check("spl_tx packet key", {8'h0, pkt[39:8]}, {8'h0, key});
          check("spl_tx header zero bits", {33'h0, pkt[7:1]}, 40'h0);
          nsym = 0;
        end
        else
        begin
          nib = -1;
          for (int i = 0; i < 16; i++)
          begin
            if (SYM_CODE[i] == trans)
              nib = i;
          end
          if (nib < 0)
            abort_run($sformatf("Link transition %0h is not a 2-of-7 code", trans));
          pkt = {4'(nib), pkt[39:4]};
          nsym++;
        end
        rand_wait(8);
        spl_tx_ack = ~spl_tx_ack;
      end
    end
  end

  // Credits must stall the link sender while the AER ack is held
  initial
  begin
    @(posedge hold_on);
    repeat (HOLD_CYCLES) @(negedge clk);
    check("link sender stalled", {39'h0, link_done < link_total}, 40'h1);
    hold_on = 1'b0;
  end

  initial
  begin
    #(NUM_LINES * 3000 + 5000);
    abort_run("Run timed out before all transactions completed");
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    seed         = 7;
    rst_n        = 1'b0;
    spl_rx_data  = '0;
    spl_tx_ack   = 1'b0;
    aer_rx_data  = '0;
    aer_rx_req_n = 1'b1;
    aer_tx_ack_n = 1'b1;
    hold_on      = 1'b0;
    rx_word      = '0;
    rx_ack_seen  = 1'b0;
    link_total   = 0;
    link_done    = 0;
    $readmemh("sim/spinn_aer_stim.txt", stim_mem);

    // Expect flag has to agree with what the op code implies
    for (int l = 0; l < NUM_LINES; l++)
    begin
      if (stim_mem[3*l] > 16'd5)
        abort_run($sformatf("Unknown operation on stimulus line %0d", l + 1));
      check($sformatf("expect flag line %0d", l + 1), {24'h0, stim_mem[3*l+2]},
            {39'h0, (stim_mem[3*l] == 16'd0) || (stim_mem[3*l] == 16'd4)});
      if (stim_mem[3*l] < 16'd4)
        link_total++;
    end

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("spl_rx_ack", {39'h0, spl_rx_ack}, 40'h0);
    check("spl_tx_data", {33'h0, spl_tx_data}, 40'h0);
    check("aer_rx_ack_n", {39'h0, aer_rx_ack_n}, 40'h1);
    check("aer_tx_req_n", {39'h0, aer_tx_req_n}, 40'h1);

    fork
      run_link_side();
      run_aer_side();
    join

    // Wait for both scoreboards to drain
    while ((aer_exp.size() != 0) || (link_exp.size() != 0))
      @(negedge clk);
    // Tail for any stray output
    repeat (50) @(negedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: logic/spinn_aer_bridge.sv
// SpiNNaker link to AER bridge top, two credit-controlled packet channels
`timescale 1ns/1ps
module spinn_aer_bridge #(
  parameter logic [15:0] KEY_PREFIX = 16'hffff,
  parameter int          FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  // Link from SpiNNaker
  input  logic [6:0]  spl_rx_data,
  output logic        spl_rx_ack,
  // Link to SpiNNaker
  output logic [6:0]  spl_tx_data,
  input  logic        spl_tx_ack,
  // AER event source
  input  logic [15:0] aer_rx_data,
  input  logic        aer_rx_req_n,
  output logic        aer_rx_ack_n,
  // AER event sink
  output logic [15:0] aer_tx_data,
  output logic        aer_tx_req_n,
  input  logic        aer_tx_ack_n
);

  // Link to AER, then AER to link
  pkt_chan_if chan_up ();
  pkt_chan_if chan_down ();

  spl_rx #(.KEY_PREFIX(KEY_PREFIX), .FIFO_DEPTH(FIFO_DEPTH)) u_spl_rx (
    .clk (clk), .rst_n (rst_n),
    .spl_rx_data (spl_rx_data), .spl_rx_ack (spl_rx_ack),
    .src (chan_up.producer)
  );

  aer_tx #(.FIFO_DEPTH(FIFO_DEPTH)) u_aer_tx (
    .clk (clk), .rst_n (rst_n), .sink (chan_up.consumer),
    .aer_tx_data (aer_tx_data), .aer_tx_req_n (aer_tx_req_n),
    .aer_tx_ack_n (aer_tx_ack_n)
  );

  aer_rx #(.KEY_PREFIX(KEY_PREFIX), .FIFO_DEPTH(FIFO_DEPTH)) u_aer_rx (
    .clk (clk), .rst_n (rst_n),
    .aer_rx_data (aer_rx_data), .aer_rx_req_n (aer_rx_req_n),
    .aer_rx_ack_n (aer_rx_ack_n), .src (chan_down.producer)
  );

  spl_tx #(.FIFO_DEPTH(FIFO_DEPTH)) u_spl_tx (
    .clk (clk), .rst_n (rst_n), .sink (chan_down.consumer),
    .spl_tx_data (spl_tx_data), .spl_tx_ack (spl_tx_ack)
  );

endmodule

// File: logic/aer_tx.sv
// AER output handshake, buffered packets out on the four-phase bus
`timescale 1ns/1ps
module aer_tx #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  pkt_chan_if.consumer sink,
  output logic [15:0]  aer_tx_data,
  output logic         aer_tx_req_n,
  input  logic         aer_tx_ack_n
);
  import spinn_aer_pkg::*;

  spl_pkt_t    head;
  logic        not_empty;
  logic        pop;
  logic        launch;
  logic        ack_s1;
  logic        ack_s2;
  logic [15:0] data_q;
  aer_state_e  state;

  pkt_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .sink      (sink),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop)
  );

  assign launch = (state == AER_IDLE) && not_empty;
  // Entry leaves only after the receiver has released ack
  assign pop    = (state == AER_RELEASE) && ack_s2;

  // Event value is the low half of the key
  always_ff @(posedge clk)
  begin
    if (launch)
      data_q <= head.key[15:0];
  end

  assign aer_tx_data = data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_s1       <= 1'b1;
      ack_s2       <= 1'b1;
      aer_tx_req_n <= 1'b1;
      state        <= AER_IDLE;
    end
    else
    begin
      ack_s1 <= aer_tx_ack_n;
      ack_s2 <= ack_s1;
      case (state)
        AER_IDLE:
        begin
          if (launch)
          begin
            aer_tx_req_n <= 1'b0;
            state        <= AER_ACTIVE;
          end
        end
        AER_ACTIVE:
        begin
          if (!ack_s2)
          begin
            aer_tx_req_n <= 1'b1;
            state        <= AER_RELEASE;
          end
        end
        AER_RELEASE:
        begin
          if (ack_s2)
            state <= AER_IDLE;
        end
        default: state <= AER_IDLE;
      endcase
    end
  end

  // Bundled data must hold for the whole req-low phase
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!aer_tx_req_n && !$past(aer_tx_req_n)) |-> $stable(aer_tx_data));

endmodule

// File: logic/aer_rx.sv
// AER input handshake, events in as prefixed parity-correct packets
`timescale 1ns/1ps
module aer_rx #(
  parameter logic [15:0] KEY_PREFIX = 16'hffff,
  parameter int          FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [15:0]  aer_rx_data,
  input  logic         aer_rx_req_n,
  output logic         aer_rx_ack_n,
  pkt_chan_if.producer src
);
  import spinn_aer_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic          req_s1;
  logic          req_s2;
  logic [15:0]   data_s1;
  logic [15:0]   data_s2;
  logic [CW-1:0] credits;
  logic          push;
  logic          valid_q;
  spl_pkt_t      pkt_q;
  aer_state_e    state;

  // Data settles before req falls, so it can share the two-stage delay
  always_ff @(posedge clk)
  begin
    data_s1 <= aer_rx_data;
    data_s2 <= data_s1;
    if (push)
      pkt_q <= make_pkt({KEY_PREFIX, data_s2});
  end

  // No credit means no ack, the sender just waits
  assign push = (state == AER_IDLE) && !req_s2 && (credits != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_s1       <= 1'b1;
      req_s2       <= 1'b1;
      aer_rx_ack_n <= 1'b1;
      valid_q      <= 1'b0;
      credits      <= CW'(FIFO_DEPTH);
      state        <= AER_IDLE;
    end
    else
    begin
      req_s1  <= aer_rx_req_n;
      req_s2  <= req_s1;
      valid_q <= push;
      credits <= credits - CW'(push) + CW'(src.credit);
      case (state)
        AER_IDLE:
        begin
          if (push)
          begin
            aer_rx_ack_n <= 1'b0;
            state        <= AER_ACTIVE;
          end
        end
        // Wait for req release, then release ack
        AER_ACTIVE:
        begin
          if (req_s2)
          begin
            aer_rx_ack_n <= 1'b1;
            state        <= AER_RELEASE;
          end
        end
        AER_RELEASE: state <= AER_IDLE;
        default:     state <= AER_IDLE;
      endcase
    end
  end

  assign src.valid = valid_q;
  assign src.pkt   = pkt_q;

endmodule

// File: logic/spl_tx.sv
// SpiNNaker link transmitter, buffered packets out as NRZ 2-of-7 symbols
`timescale 1ns/1ps
module spl_tx #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  pkt_chan_if.consumer sink,
  output logic [6:0]   spl_tx_data,
  input  logic         spl_tx_ack
);
  import spinn_aer_pkg::*;

  spl_pkt_t    head;
  logic [39:0] head_bits;
  logic        not_empty;
  logic        pop;
  logic        ack_s1;
  logic        ack_s2;
  logic        ack_seen;
  logic        ack_chg;
  logic [3:0]  idx;
  logic [3:0]  nib;
  tx_state_e   state;

  pkt_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .sink      (sink),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop)
  );

  // Ack is a toggle, so compare against the last recorded level
  assign ack_chg   = (ack_s2 != ack_seen);
  assign head_bits = head;
  assign nib       = head_bits[{idx, 2'b00} +: 4];

  // Head stays put until EOP leaves
  assign pop = (state == TX_SEND) && ack_chg && (idx == 4'(SPL_SYMS));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_s1 <= 1'b0;
      ack_s2 <= 1'b0;
    end
    else
    begin
      ack_s1 <= spl_tx_ack;
      ack_s2 <= ack_s1;
    end
  end

  // --------------------------------------------------
  // Symbol sequencer
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= TX_IDLE;
      spl_tx_data <= '0;
      ack_seen    <= 1'b0;
      idx         <= '0;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          // First nibble straight away, note the ack level it must change from
          if (not_empty)
          begin
            spl_tx_data <= spl_tx_data ^ code_2of7(nib);
            ack_seen    <= ack_s2;
            idx         <= 4'd1;
            state       <= TX_SEND;
          end
        end
        TX_SEND:
        begin
          if (ack_chg)
          begin
            ack_seen <= ack_s2;
            if (idx == 4'(SPL_SYMS))
            begin
              spl_tx_data <= spl_tx_data ^ EOP_CODE;
              state       <= TX_WAIT_ACK;
            end
            else
            begin
              spl_tx_data <= spl_tx_data ^ code_2of7(nib);
              idx         <= idx + 1'b1;
            end
          end
        end
        TX_WAIT_ACK:
        begin
          // EOP ack closes the packet
          if (ack_chg)
          begin
            ack_seen <= ack_s2;
            idx      <= '0;
            state    <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Each link transition is one complete 2-of-7 code
  a_two_wires: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(spl_tx_data) |-> ($countones(spl_tx_data ^ $past(spl_tx_data)) == 2));

endmodule

// File: logic/spl_rx.sv
// SpiNNaker link receiver that turns NRZ 2-of-7 symbols into checked packets sent on credit
`timescale 1ns/1ps
module spl_rx #(
  parameter logic [15:0] KEY_PREFIX = 16'hffff,
  parameter int          FIFO_DEPTH = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [6:0]   spl_rx_data,
  output logic         spl_rx_ack,
  pkt_chan_if.producer src
);
  import spinn_aer_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [6:0]    data_s1;
  logic [6:0]    data_s2;
  logic [6:0]    data_s3;
  logic [6:0]    last_word;
  logic [5:0]    sym;
  logic          accept;
  logic          pkt_good;
  logic          push;
  logic [3:0]    sym_cnt;
  logic [CW-1:0] credits;
  spl_pkt_t      shift_q;
  spl_pkt_t      pkt_q;
  logic          valid_q;
  rx_state_e     state;

  // --------------------------------------------------
  // Input synchronizer and symbol detect
  // --------------------------------------------------

  // Third stage only feeds the two-sample stability check
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_s1 <= '0;
      data_s2 <= '0;
      data_s3 <= '0;
    end
    else
    begin
      data_s1 <= spl_rx_data;
      data_s2 <= data_s1;
      data_s3 <= data_s2;
    end
  end

  // Transition against the last accepted word
  assign sym    = decode_2of7(data_s2 ^ last_word);
  // No new symbols while a good packet waits for a credit
  assign accept = sym[5] && (data_s2 == data_s3) && (state != RX_DELIVER);

  // Count, parity and prefix all have to hold
  assign pkt_good = (sym_cnt == 4'(SPL_SYMS)) && pkt_parity_ok(shift_q)
                    && (shift_q.key[31:16] == KEY_PREFIX);

  // Push on EOP with credit or later once a credit comes back
  assign push = (credits != '0)
                && ((accept && sym[4] && pkt_good) || (state == RX_DELIVER));

  // --------------------------------------------------
  // Packet assembly
  // --------------------------------------------------

  // LS nibble first ends up in bits 3:0 after ten shifts
  always_ff @(posedge clk)
  begin
    if (accept && !sym[4])
      shift_q <= {sym[3:0], shift_q[39:4]};
    if (push)
      pkt_q <= shift_q;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= RX_IDLE;
      last_word  <= '0;
      sym_cnt    <= '0;
      spl_rx_ack <= 1'b0;
      valid_q    <= 1'b0;
    end
    else
    begin
      valid_q <= push;
      if (accept)
        last_word <= data_s2;
      case (state)
        RX_IDLE, RX_COLLECT:
        begin
          if (accept && !sym[4])
          begin
            // Data nibble with a count that saturates on runaway packets
            if (sym_cnt != 4'hf)
              sym_cnt <= sym_cnt + 1'b1;
            spl_rx_ack <= ~spl_rx_ack;
            state      <= RX_COLLECT;
          end
          else if (accept)
          begin
            // EOP acks now unless a good packet has no credit
            sym_cnt <= '0;
            if (pkt_good && (credits == '0))
              state <= RX_DELIVER;
            else
            begin
              spl_rx_ack <= ~spl_rx_ack;
              state      <= RX_IDLE;
            end
          end
        end
        RX_DELIVER:
        begin
          // EOP ack held back to stall the link sender
          if (push)
          begin
            spl_rx_ack <= ~spl_rx_ack;
            state      <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Credits start full and drop by one per push
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credits <= CW'(FIFO_DEPTH);
    else
      credits <= credits - CW'(push) + CW'(src.credit);
  end

  assign src.valid = valid_q;
  assign src.pkt   = pkt_q;

  // Consumer never returns more credits than it has entries
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CW'(FIFO_DEPTH));

endmodule

// File: logic/pkt_fifo.sv
// Circular packet FIFO that returns one credit per popped entry
`timescale 1ns/1ps
module pkt_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  pkt_chan_if.consumer            sink,
  output spinn_aer_pkg::spl_pkt_t head,
  output logic                    not_empty,
  input  logic                    pop
);
  import spinn_aer_pkg::*;

  localparam int PW = $clog2(FIFO_DEPTH);
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  spl_pkt_t      mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_pop;

  assign not_empty   = (count != '0);
  assign do_pop      = pop && not_empty;
  assign head        = mem[rd_ptr];
  // Credit goes back on the same cycle as the pop
  assign sink.credit = do_pop;

  // Storage, no reset needed
  always_ff @(posedge clk)
  begin
    if (sink.valid)
      mem[wr_ptr] <= sink.pkt;
  end

  // Pointers wrap at FIFO_DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (sink.valid)
        wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(sink.valid) - CW'(do_pop);
    end
  end

  // Producer credit accounting must keep pushes off a full FIFO
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    sink.valid |-> (count < CW'(FIFO_DEPTH)));

endmodule

// File: logic/pkt_chan_if.sv
// Packet channel between a producer and a consumer FIFO, with credit return
`timescale 1ns/1ps
interface pkt_chan_if;
  import spinn_aer_pkg::*;

  // One-cycle push strobe, only ever raised with a credit in hand
  logic     valid;
  spl_pkt_t pkt;
  // One-cycle pulse per popped entry
  logic     credit;

  modport producer (
    output valid,
    output pkt,
    input  credit
  );

  modport consumer (
    input  valid,
    input  pkt,
    output credit
  );

endinterface

// File: logic/spinn_aer_pkg.sv
// Shared packet type, FSM states and 2-of-7 link code helpers for the bridge
package spinn_aer_pkg;

  // --------------------------------------------------
  // Packet layout
  // --------------------------------------------------

  // Key above header, so bit 0 of the vector is the header parity bit
  // Header nibble 0 is the first symbol on the wire
  typedef struct packed {
    logic [31:0] key;
    logic [7:0]  header;
  } spl_pkt_t;

  // Data symbols per short packet, EOP not counted
  localparam int SPL_SYMS = 10;

  // End of packet flips the two top wires
  localparam logic [6:0] EOP_CODE = 7'b1100000;

  // --------------------------------------------------
  // FSM states
  // --------------------------------------------------
  typedef enum logic [1:0] {RX_IDLE, RX_COLLECT, RX_DELIVER} rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_WAIT_ACK} tx_state_e;
  typedef enum logic [1:0] {AER_IDLE, AER_ACTIVE, AER_RELEASE} aer_state_e;

  // --------------------------------------------------
  // 2-of-7 code helpers
  // --------------------------------------------------

  // Nibble to wire pattern, two wires per code
  function automatic logic [6:0] code_2of7(input logic [3:0] nib);
    logic [6:0] code;
    case (nib)
      4'h0:    code = 7'b0010001;
      4'h1:    code = 7'b0010010;
      4'h2:    code = 7'b0010100;
      4'h3:    code = 7'b0011000;
      4'h4:    code = 7'b0100001;
      4'h5:    code = 7'b0100010;
      4'h6:    code = 7'b0100100;
      4'h7:    code = 7'b0101000;
      4'h8:    code = 7'b1000001;
      4'h9:    code = 7'b1000010;
      4'ha:    code = 7'b1000100;
      4'hb:    code = 7'b1001000;
      4'hc:    code = 7'b0000011;
      4'hd:    code = 7'b0000110;
      4'he:    code = 7'b0001100;
      default: code = 7'b0001001;
    endcase
    return code;
  endfunction

  // Transition pattern to {valid, eop, nibble}
  // Incomplete or out-of-band patterns give all zeros
  function automatic logic [5:0] decode_2of7(input logic [6:0] trans);
    logic [5:0] res;
    res = 6'b000000;
    for (int i = 0; i < 16; i++)
    begin
      if (trans == code_2of7(4'(i)))
        res = {2'b10, 4'(i)};
    end
    if (trans == EOP_CODE)
      res = 6'b110000;
    return res;
  endfunction

  // Odd number of ones over all 40 bits
  function automatic logic pkt_parity_ok(input spl_pkt_t pkt);
    return ^pkt;
  endfunction

  // Header is seven zeros plus the bit that makes the packet odd
  function automatic spl_pkt_t make_pkt(input logic [31:0] key);
    spl_pkt_t pkt;
    pkt.key    = key;
    pkt.header = {7'b0000000, ~(^key)};
    return pkt;
  endfunction

endpackage
